//--- sources.f
rtl/uart_axi_pkg.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/uart_axi_bridge.sv
rtl/register_block.sv
rtl/axiuart_top.sv
tb/clock_gen.sv
tb/axiuart_props.sv
tb/axiuart_tb.sv

//--- tb/axiuart_tests.txt
# name op index wdata status rdata, all hex except name
# rdata is checked only for reads answered with status 00
scr_wr      A5 01 12345678 00 00000000
scr_rd      5A 01 00000000 00 12345678
status_wr   A5 02 DEADBEEF 01 00000000
bad_idx_rd  5A 09 00000000 01 00000000
bad_op      33 00 00000000 02 00000000
dis_wr      A5 00 00000000 00 00000000
dis_rd      5A 01 00000000 03 00000000
dis_scr_wr  A5 01 CAFEF00D 03 00000000
en_wr       A5 00 00000001 00 00000000
scr_rd2     5A 01 00000000 00 12345678
rxcnt_rd    5A 03 00000000 00 0000000A
txcnt_rd    5A 04 00000000 00 0000000B
clr_wr      A5 00 00000003 00 00000000
rxcnt_rd2   5A 03 00000000 00 00000001
bad_op2     00 00 00000000 02 00000000
status_rd   5A 02 00000000 00 00000201
txcnt_rd2   5A 04 00000000 00 00000004

//--- tb/axiuart_tb.sv
`timescale 1ns/1ns
`default_nettype none

module axiuart_tb;
    import uart_axi_pkg::*;

    wire  clk;
    wire  reset;
    logic uart_rx_line;
    wire  uart_tx_line;

    // Test table, one entry per file line
    string       test_name   [$];
    logic [7:0]  test_op     [$];
    logic [7:0]  test_index  [$];
    logic [31:0] test_wdata  [$];
    logic [7:0]  test_status [$];
    logic [31:0] test_rdata  [$];

    logic [16:0] lfsr;           // Gap generator state
    logic        loaded = 1'b0;  // Arms the watchdog
    int          pass_count = 0;
    int          fail_count = 0;

    clock_gen i_clock (
        .clk   (clk),
        .reset (reset)
    );

    axiuart_top i_dut (
        .clk     (clk),
        .reset   (reset),
        .uart_rx (uart_rx_line),
        .uart_tx (uart_tx_line)
    );

    // Fibonacci LFSR, taps 17 and 14
    function automatic logic [16:0] lfsr_next(input logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};
    endfunction

    // Four LFSR bits give 0..15 idle bit periods
    task automatic draw_gap(output int gap);
        gap = 0;
        repeat (4) begin
            lfsr = lfsr_next(lfsr);
            gap  = (gap << 1) | lfsr[0];
        end
    endtask

    task automatic load_tests();
        int          fd;
        int          code;
        int          c;
        string       name;
        logic [7:0]  op;
        logic [7:0]  idx;
        logic [7:0]  st;
        logic [31:0] wd;
        logic [31:0] rd;
        logic        done;
        fd   = $fopen("tb/axiuart_tests.txt", "r");
        done = 1'b0;
        if (fd == 0) begin
            $display("Could not open the test file tb/axiuart_tests.txt");
            fail_count++;
            done = 1'b1;
        end
        while (!done) begin
            code = $fscanf(fd, "%s", name);
            if (code != 1) begin
                done = 1'b1;
            end else if (name.getc(0) == "#") begin
                c = $fgetc(fd); // Skip the rest of a comment line
                while (c != 10 && c != -1)
                    c = $fgetc(fd);
            end else begin
                code = $fscanf(fd, "%h %h %h %h %h", op, idx, wd, st, rd);
                if (code == 5) begin
                    test_name.push_back(name);
                    test_op.push_back(op);
                    test_index.push_back(idx);
                    test_wdata.push_back(wd);
                    test_status.push_back(st);
                    test_rdata.push_back(rd);
                end else begin
                    $display("Test file line for %s is malformed", name);
                    fail_count++;
                end
            end
        end
        if (fd != 0)
            $fclose(fd);
        if (test_name.size() == 0) begin
            $display("No tests found in the test file");
            fail_count++;
        end
    endtask

    // Called on a rising edge, returns on a rising edge
    task automatic send_bit(input logic b);
        uart_rx_line <= b;
        repeat (clks_per_bit) @(posedge clk);
    endtask

    task automatic send_byte(input logic [7:0] b);
        send_bit(1'b0); // Start
        for (int i = 0; i < 8; i++)
            send_bit(b[i]); // LSB first
        send_bit(1'b1); // Stop
    endtask

    task automatic send_frame(input logic [47:0] frame, input int nbytes);
        int gap;
        for (int k = 0; k < nbytes; k++) begin
            if (k > 0) begin
                draw_gap(gap);
                repeat (gap) send_bit(1'b1); // Idle line between bytes
            end
            send_byte(frame[8*k +: 8]);
        end
    endtask

    // Samples on falling clock edges, near mid-bit
    task automatic receive_byte(output logic [7:0] b, output logic ok);
        @(negedge uart_tx_line);
        repeat (clks_per_bit / 2) @(negedge clk);
        ok = (uart_tx_line == 1'b0);
        for (int i = 0; i < 8; i++) begin
            repeat (clks_per_bit) @(negedge clk);
            b[i] = uart_tx_line;
        end
        repeat (clks_per_bit) @(negedge clk);
        if (uart_tx_line != 1'b1)
            ok = 1'b0; // Stop bit low
    endtask

    task automatic receive_answer(input logic [7:0] op, output logic [39:0] answer,
                                  output logic ok);
        logic [7:0] b;
        logic       byte_ok;
        answer = '0;
        receive_byte(b, byte_ok);
        answer[7:0] = b;
        ok = byte_ok;
        // Data follows only a good read status
        if (op == op_read && b == st_ok) begin
            for (int k = 1; k < 5; k++) begin
                receive_byte(b, byte_ok);
                answer[8*k +: 8] = b;
                ok = ok && byte_ok;
            end
        end
    endtask

    task automatic run_test(input int t);
        logic [47:0] frame;
        logic [39:0] answer;
        logic [7:0]  op;
        int          nbytes;
        logic        framing_ok;
        logic        extra;
        int          errs;
        op     = test_op[t];
        frame  = {test_wdata[t], test_index[t], op}; // Write data LSB first
        nbytes = (op == op_write) ? 6 : (op == op_read) ? 2 : 1;
        errs   = 0;
        extra  = 1'b0;
        fork
            send_frame(frame, nbytes);
            receive_answer(op, answer, framing_ok);
        join
        // Line must stay quiet after the expected bytes
        repeat (12 * clks_per_bit) begin
            @(negedge clk);
            if (uart_tx_line == 1'b0)
                extra = 1'b1;
        end
        @(posedge clk);
        if (!framing_ok) begin
            $display("%s: an answer byte had a bad start or stop bit", test_name[t]);
            errs++;
        end
        if (answer[7:0] != test_status[t]) begin
            $display("[ERROR] %s: status expected 0x%02h actual 0x%02h",
                     test_name[t], test_status[t], answer[7:0]);
            errs++;
        end else if (op == op_read && test_status[t] == st_ok) begin
            if (answer[39:8] != test_rdata[t]) begin
                $display("[ERROR] %s: read data expected 0x%08h actual 0x%08h",
                         test_name[t], test_rdata[t], answer[39:8]);
                errs++;
            end
        end
        if (extra) begin
            $display("%s: the answer carried more bytes than expected", test_name[t]);
            errs++;
        end
        if (errs == 0) begin
            pass_count++;
            $display("%s: passed", test_name[t]);
        end else begin
            fail_count++;
            $display("%s: failed with %0d errors", test_name[t], errs);
        end
    endtask

    initial begin : main
        uart_rx_line = 1'b1; // Idle line
        lfsr         = 17'd93632;
        load_tests();
        if (test_name.size() > 0)
            loaded = 1'b1;
        @(posedge clk);
        while (reset)
            @(posedge clk);
        repeat (2 * clks_per_bit) @(posedge clk);
        for (int t = 0; t < test_name.size(); t++)
            run_test(t);
        $display("Tests: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0 && pass_count > 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // 40 byte times of 10 bits per test
    initial begin : watchdog
        wait (loaded);
        repeat (test_name.size() * 40 * 10 * clks_per_bit) @(posedge clk);
        $display("Timeout, the tests did not finish within %0d byte times",
                 test_name.size() * 40);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/axiuart_props.sv
`timescale 1ns/1ns
`default_nettype none

module axiuart_props (
    input logic clk,
    input logic reset,
    input logic awvalid,
    input logic awready,
    input logic wvalid,
    input logic wready,
    input logic bvalid,
    input logic arready,
    input logic rvalid
);

    // Write address held until taken
    aw_hold: assert property (@(posedge clk) disable iff (reset)
        awvalid && !awready |=> awvalid)
        else $error("awvalid dropped before awready");

    // Read data one cycle after acceptance
    r_follow: assert property (@(posedge clk) disable iff (reset)
        arready |=> rvalid)
        else $error("rvalid missing one cycle after arready");

    r_cause: assert property (@(posedge clk) disable iff (reset)
        $rose(rvalid) |-> $past(arready))
        else $error("rvalid rose without a prior arready");

    // Response only after both write channels were taken
    b_cause: assert property (@(posedge clk) disable iff (reset)
        $rose(bvalid) |-> $past(awvalid && awready && wvalid && wready))
        else $error("bvalid rose without a prior write acceptance");

endmodule

bind register_block axiuart_props i_props (.*);

`default_nettype wire

//--- tb/clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module clock_gen (
    output logic clk,
    output logic reset
);

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Held for five rising edges, released on an edge
    initial begin
        reset = 1'b1;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

//--- rtl/axiuart_top.sv
`timescale 1ns/1ns
`default_nettype none

module axiuart_top (
    input  logic clk,
    input  logic reset,
    input  logic uart_rx,
    output logic uart_tx
);
    import uart_axi_pkg::*;

    // Serial byte links
    logic [7:0] rx_data;
    logic       rx_valid;
    logic [7:0] tx_data;
    logic       tx_start;
    logic       tx_ready;

    // Internal AXI4-Lite bus, bridge is the only master
    logic [addr_width-1:0]   awaddr;
    logic                    awvalid;
    logic                    awready;
    logic [data_width-1:0]   wdata;
    logic [data_width/8-1:0] wstrb;
    logic                    wvalid;
    logic                    wready;
    axi_resp_t               bresp;
    logic                    bvalid;
    logic                    bready;
    logic [addr_width-1:0]   araddr;
    logic                    arvalid;
    logic                    arready;
    logic [data_width-1:0]   rdata;
    axi_resp_t               rresp;
    logic                    rvalid;
    logic                    rready;

    // Control and statistics
    logic        bridge_enable;
    logic        reset_stats;
    logic        bridge_busy;
    logic [7:0]  error_code;
    logic [15:0] rx_count;
    logic [15:0] tx_count;

    uart_rx uart_rx_inst (
        .clk      (clk),
        .reset    (reset),
        .uart_rx  (uart_rx),
        .rx_data  (rx_data),
        .rx_valid (rx_valid)
    );

    uart_tx uart_tx_inst (
        .clk      (clk),
        .reset    (reset),
        .tx_data  (tx_data),
        .tx_start (tx_start),
        .tx_ready (tx_ready),
        .uart_tx  (uart_tx)
    );

    uart_axi_bridge bridge_inst (
        .clk           (clk),
        .reset         (reset),
        .rx_data       (rx_data),
        .rx_valid      (rx_valid),
        .tx_data       (tx_data),
        .tx_start      (tx_start),
        .tx_ready      (tx_ready),
        .awaddr        (awaddr),
        .awvalid       (awvalid),
        .awready       (awready),
        .wdata         (wdata),
        .wstrb         (wstrb),
        .wvalid        (wvalid),
        .wready        (wready),
        .bresp         (bresp),
        .bvalid        (bvalid),
        .bready        (bready),
        .araddr        (araddr),
        .arvalid       (arvalid),
        .arready       (arready),
        .rdata         (rdata),
        .rresp         (rresp),
        .rvalid        (rvalid),
        .rready        (rready),
        .bridge_enable (bridge_enable),
        .reset_stats   (reset_stats),
        .bridge_busy   (bridge_busy),
        .error_code    (error_code),
        .rx_count      (rx_count),
        .tx_count      (tx_count)
    );

    register_block register_block_inst (
        .clk           (clk),
        .reset         (reset),
        .awaddr        (awaddr),
        .awvalid       (awvalid),
        .awready       (awready),
        .wdata         (wdata),
        .wstrb         (wstrb),
        .wvalid        (wvalid),
        .wready        (wready),
        .bresp         (bresp),
        .bvalid        (bvalid),
        .bready        (bready),
        .araddr        (araddr),
        .arvalid       (arvalid),
        .arready       (arready),
        .rdata         (rdata),
        .rresp         (rresp),
        .rvalid        (rvalid),
        .rready        (rready),
        .bridge_enable (bridge_enable),
        .reset_stats   (reset_stats),
        .bridge_busy   (bridge_busy),
        .error_code    (error_code),
        .rx_count      (rx_count),
        .tx_count      (tx_count)
    );

endmodule

`default_nettype wire

//--- rtl/register_block.sv
`timescale 1ns/1ns
`default_nettype none

module register_block (
    input  logic                                  clk,
    input  logic                                  reset,
    // AXI4-Lite slave
    input  logic [uart_axi_pkg::addr_width-1:0]   awaddr,
    input  logic                                  awvalid,
    output logic                                  awready,
    input  logic [uart_axi_pkg::data_width-1:0]   wdata,
    input  logic [uart_axi_pkg::data_width/8-1:0] wstrb,
    input  logic                                  wvalid,
    output logic                                  wready,
    output uart_axi_pkg::axi_resp_t               bresp,
    output logic                                  bvalid,
    input  logic                                  bready,
    input  logic [uart_axi_pkg::addr_width-1:0]   araddr,
    input  logic                                  arvalid,
    output logic                                  arready,
    output logic [uart_axi_pkg::data_width-1:0]   rdata,
    output uart_axi_pkg::axi_resp_t               rresp,
    output logic                                  rvalid,
    input  logic                                  rready,
    // Bridge control and status
    output logic                                  bridge_enable,
    output logic                                  reset_stats,
    input  logic                                  bridge_busy,
    input  logic [7:0]                            error_code,
    input  logic [15:0]                           rx_count,
    input  logic [15:0]                           tx_count
);
    import uart_axi_pkg::*;

    logic [addr_width-3:0] wr_index;
    logic [addr_width-3:0] rd_index;
    logic [data_width-1:0] scratch;

    assign wr_index = awaddr[addr_width-1:2];
    assign rd_index = araddr[addr_width-1:2];
    assign wready   = awready; // Address and data taken together

    // Write channel
    always_ff @(posedge clk) begin
        if (reset) begin
            awready       <= 1'b0;
            bvalid        <= 1'b0;
            bridge_enable <= 1'b1; // Bridge usable out of reset
            reset_stats   <= 1'b0;
            scratch       <= '0;
        end else begin
            awready     <= awvalid && wvalid && !awready && !bvalid;
            reset_stats <= 1'b0;
            if (awready) begin
                bvalid <= 1'b1;
                bresp  <= resp_okay;
                case (wr_index)
                    reg_control: begin
                        if (wstrb[0]) begin
                            bridge_enable <= wdata[0];
                            reset_stats   <= wdata[1]; // Self clearing
                        end
                    end
                    reg_scratch: begin
                        for (int b = 0; b < data_width / 8; b++) begin
                            if (wstrb[b])
                                scratch[8*b +: 8] <= wdata[8*b +: 8];
                        end
                    end
                    default: bresp <= resp_slverr; // Read only or unmapped
                endcase
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    // Read channel
    always_ff @(posedge clk) begin
        if (reset) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            arready <= arvalid && !arready && !rvalid;
            if (arready) begin
                rvalid <= 1'b1; // One cycle after acceptance
                rresp  <= resp_okay;
                case (rd_index)
                    reg_control:  rdata <= data_width'(bridge_enable); // Clear bit reads 0
                    reg_scratch:  rdata <= scratch;
                    reg_status:   rdata <= {16'd0, error_code, 7'd0, bridge_busy};
                    reg_rx_count: rdata <= data_width'(rx_count);
                    reg_tx_count: rdata <= data_width'(tx_count);
                    default: begin
                        rdata <= '0;
                        rresp <= resp_slverr;
                    end
                endcase
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/uart_axi_bridge.sv
`timescale 1ns/1ns
`default_nettype none

module uart_axi_bridge (
    input  logic                                  clk,
    input  logic                                  reset,
    // Serial byte side
    input  logic [7:0]                            rx_data,
    input  logic                                  rx_valid,
    output logic [7:0]                            tx_data,
    output logic                                  tx_start,
    input  logic                                  tx_ready,
    // AXI4-Lite master
    output logic [uart_axi_pkg::addr_width-1:0]   awaddr,
    output logic                                  awvalid,
    input  logic                                  awready,
    output logic [uart_axi_pkg::data_width-1:0]   wdata,
    output logic [uart_axi_pkg::data_width/8-1:0] wstrb,
    output logic                                  wvalid,
    input  logic                                  wready,
    input  uart_axi_pkg::axi_resp_t               bresp,
    input  logic                                  bvalid,
    output logic                                  bready,
    output logic [uart_axi_pkg::addr_width-1:0]   araddr,
    output logic                                  arvalid,
    input  logic                                  arready,
    input  logic [uart_axi_pkg::data_width-1:0]   rdata,
    input  uart_axi_pkg::axi_resp_t               rresp,
    input  logic                                  rvalid,
    output logic                                  rready,
    // Control and statistics
    input  logic                                  bridge_enable,
    input  logic                                  reset_stats,
    output logic                                  bridge_busy,
    output logic [7:0]                            error_code,
    output logic [15:0]                           rx_count,
    output logic [15:0]                           tx_count
);
    import uart_axi_pkg::*;

    bridge_state_t         state;
    logic                  is_write;  // Frame kind after the opcode
    logic [7:0]            reg_index;
    logic [1:0]            byte_cnt;  // Data bytes in or out
    logic [data_width-1:0] data_buf;  // Write data, later read data
    frame_status_t         status;

    // Index to byte address, upper index bits dropped
    assign awaddr  = {reg_index[addr_width-3:0], 2'b00};
    assign araddr  = {reg_index[addr_width-3:0], 2'b00};
    assign wdata   = data_buf;
    assign wstrb   = '1;                    // Always full words
    assign bready  = (state == bus_write);  // Never stalls the slave
    assign rready  = (state == bus_read);

    // Answer bytes, status first
    assign tx_data  = (state == send_status) ? status : data_buf[7:0];
    assign tx_start = tx_ready && (state == send_status || state == send_data);

    assign bridge_busy = (state != idle);
    assign error_code  = status;

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= idle;
            is_write <= 1'b0;
            byte_cnt <= 2'd0;
            status   <= st_ok;
            awvalid  <= 1'b0;
            wvalid   <= 1'b0;
            arvalid  <= 1'b0;
            rx_count <= 16'd0;
            tx_count <= 16'd0;
        end else begin
            case (state)
                idle: begin
                    if (rx_valid) begin
                        if (rx_data == op_write || rx_data == op_read) begin
                            is_write <= (rx_data == op_write);
                            state    <= get_addr;
                        end else begin
                            status <= st_bad_command; // Answer right away
                            state  <= send_status;
                        end
                    end
                end
                get_addr: begin
                    if (rx_valid) begin
                        reg_index <= rx_data;
                        byte_cnt  <= 2'd0;
                        if (is_write) begin
                            state <= get_data;
                        end else begin
                            rx_count <= rx_count + 1'b1; // Read frame complete
                            if (bridge_enable) begin
                                arvalid <= 1'b1;
                                state   <= bus_read;
                            end else begin
                                status <= st_disabled;
                                state  <= send_status;
                            end
                        end
                    end
                end
                get_data: begin
                    if (rx_valid) begin
                        data_buf <= {rx_data, data_buf[data_width-1:8]}; // LSB first
                        byte_cnt <= byte_cnt + 1'b1;
                        if (byte_cnt == 2'd3) begin
                            rx_count <= rx_count + 1'b1;
                            // Control stays writable so the host can re-enable
                            if (bridge_enable || reg_index == 8'(reg_control)) begin
                                awvalid <= 1'b1;
                                wvalid  <= 1'b1;
                                state   <= bus_write;
                            end else begin
                                status <= st_disabled;
                                state  <= send_status;
                            end
                        end
                    end
                end
                bus_write: begin
                    if (awready)
                        awvalid <= 1'b0;
                    if (wready)
                        wvalid <= 1'b0;
                    if (bvalid) begin
                        status <= (bresp == resp_okay) ? st_ok : st_slave_error;
                        state  <= send_status;
                    end
                end
                bus_read: begin
                    if (arready)
                        arvalid <= 1'b0;
                    if (rvalid) begin
                        data_buf <= rdata;
                        status   <= (rresp == resp_okay) ? st_ok : st_slave_error;
                        state    <= send_status;
                    end
                end
                send_status: begin
                    if (tx_ready) begin
                        byte_cnt <= 2'd0;
                        if (status == st_ok && !is_write) begin
                            state <= send_data; // Good read carries data
                        end else begin
                            tx_count <= tx_count + 1'b1;
                            state    <= idle;
                        end
                    end
                end
                send_data: begin
                    if (tx_ready) begin
                        data_buf <= data_buf >> 8;
                        byte_cnt <= byte_cnt + 1'b1;
                        if (byte_cnt == 2'd3) begin
                            tx_count <= tx_count + 1'b1; // Last byte handed over
                            state    <= idle;
                        end
                    end
                end
                default: state <= idle;
            endcase
            if (reset_stats) begin
                rx_count <= 16'd0; // Overrides any count this cycle
                tx_count <= 16'd0;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/uart_tx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_tx (
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] tx_data,
    input  logic       tx_start,
    output logic       tx_ready,
    output logic       uart_tx
);
    import uart_axi_pkg::*;

    logic [9:0]            shift;     // Stop, data, start
    logic [3:0]            bits_left;
    logic [tick_width-1:0] tick_cnt;

    assign tx_ready = (bits_left == 4'd0);
    assign uart_tx  = shift[0];

    always_ff @(posedge clk) begin
        if (reset) begin
            shift     <= '1; // Line high while idle
            bits_left <= 4'd0;
            tick_cnt  <= '0;
        end else if (tx_ready) begin
            if (tx_start) begin
                shift     <= {1'b1, tx_data, 1'b0};
                bits_left <= 4'd10;
                tick_cnt  <= tick_width'(clks_per_bit - 1);
            end
        end else if (tick_cnt != 0) begin
            tick_cnt <= tick_cnt - 1'b1;
        end else begin
            // Next bit, ones fill in behind
            shift     <= {1'b1, shift[9:1]};
            bits_left <= bits_left - 1'b1;
            tick_cnt  <= tick_width'(clks_per_bit - 1);
        end
    end

endmodule

`default_nettype wire

//--- rtl/uart_rx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_rx (
    input  logic       clk,
    input  logic       reset,
    input  logic       uart_rx,
    output logic [7:0] rx_data,
    output logic       rx_valid
);
    import uart_axi_pkg::*;

    logic [2:0]            line_sync; // Two sync flops plus one of history
    logic                  busy;
    logic [3:0]            bit_idx;   // 0 start, 1..8 data, 9 stop
    logic [tick_width-1:0] tick_cnt;
    logic [7:0]            shift;

    assign rx_data = shift;

    always_ff @(posedge clk) begin
        if (reset) begin
            line_sync <= 3'b111; // Idle line is high
            busy      <= 1'b0;
            bit_idx   <= 4'd0;
            tick_cnt  <= '0;
            rx_valid  <= 1'b0;
        end else begin
            line_sync <= {line_sync[1:0], uart_rx};
            rx_valid  <= 1'b0; // One cycle strobe
            if (!busy) begin
                if (line_sync[2:1] == 2'b10) begin // Start edge
                    busy     <= 1'b1;
                    bit_idx  <= 4'd0;
                    tick_cnt <= tick_width'(clks_per_bit / 2 - 1); // Aim at mid start bit
                end
            end else if (tick_cnt != 0) begin
                tick_cnt <= tick_cnt - 1'b1;
            end else begin
                // Middle of a bit
                tick_cnt <= tick_width'(clks_per_bit - 1);
                bit_idx  <= bit_idx + 1'b1;
                if (bit_idx == 4'd0) begin
                    if (line_sync[1])
                        busy <= 1'b0; // Glitch, not a real start bit
                end else if (bit_idx == 4'd9) begin
                    busy     <= 1'b0;
                    rx_valid <= line_sync[1]; // Low stop bit drops the byte
                end else begin
                    shift <= {line_sync[1], shift[7:1]}; // LSB arrives first
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/uart_axi_pkg.sv
`default_nettype none

package uart_axi_pkg;

    // Serial bit timing, short for simulation
    localparam int clks_per_bit = 8;
    localparam int tick_width   = $clog2(clks_per_bit); // Bit period counter width

    // Internal AXI4-Lite bus
    localparam int addr_width = 8;
    localparam int data_width = 32;

    // Register word indices, byte address is index << 2
    localparam logic [addr_width-3:0] reg_control  = 6'd0; // Enable and stats clear
    localparam logic [addr_width-3:0] reg_scratch  = 6'd1;
    localparam logic [addr_width-3:0] reg_status   = 6'd2; // Read only
    localparam logic [addr_width-3:0] reg_rx_count = 6'd3; // Read only
    localparam logic [addr_width-3:0] reg_tx_count = 6'd4; // Read only

    // First byte of a command frame
    typedef enum logic [7:0] {
        op_write = 8'hA5, // Followed by index and four data bytes
        op_read  = 8'h5A  // Followed by index only
    } frame_op_t;

    // First byte of every answer
    typedef enum logic [7:0] {
        st_ok          = 8'h00,
        st_slave_error = 8'h01,
        st_bad_command = 8'h02,
        st_disabled    = 8'h03
    } frame_status_t;

    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_slverr = 2'b10
    } axi_resp_t;

    typedef enum logic [2:0] {
        idle,
        get_addr,     // Index byte
        get_data,     // Four write data bytes
        bus_write,
        bus_read,
        send_status,
        send_data     // Read data, LSB first
    } bridge_state_t;

endpackage

`default_nettype wire
